/* common/kronos_types.sv */
// ====================
// Shared types and ALU select codes for the execute stage and ALU.
// Imported by every RTL module and by the testbench.
// ====================

package kronos_types;

    // ====================
    // Data widths

    // Operand or result word
    typedef logic [31:0] word_t;

    // Destination register index
    typedef logic [4:0] reg_addr_t;

    // Memory access size, byte/half/word
    typedef logic [1:0] data_size_t;

    // ====================
    // ALU result select

    typedef logic [2:0] alu_sel_t;

    // Adder output, also used for sub, lui and auipc
    localparam alu_sel_t ALU_ADD = 3'd0;

    // Bitwise operations
    localparam alu_sel_t ALU_AND = 3'd1;
    localparam alu_sel_t ALU_OR  = 3'd2;
    localparam alu_sel_t ALU_XOR = 3'd3;

    // Barrel shifter, direction and fill from rev/uns
    localparam alu_sel_t ALU_SHIFT = 3'd4;

    // Comparator result zero-extended, for slt/sltu
    localparam alu_sel_t ALU_COMP = 3'd5;

    // Codes 6 and 7 are not used by the decoder

endpackage

/* alu/kronos_alu_arith.sv */
// ====================
// Arithmetic half of the ALU: adder, branch comparator, address adder.
// Purely combinational, instantiated by kronos_alu.
// ====================

`timescale 1ns/1ps

module kronos_alu_arith
    import kronos_types::*;
(
    input  word_t op1,
    input  word_t op2,
    input  word_t op3,
    input  word_t op4,
    input  logic  cin,
    input  logic  inv,
    input  logic  uns,
    input  logic  eq,
    input  logic  align,
    output word_t sum,
    output logic  cmp,
    output word_t addr
);

    word_t adder_op2;
    word_t addr_raw;
    logic  cmp_eq;
    logic  cmp_lt;
    logic  cmp_raw;

    // ====================
    // Adder

    // Subtract is inv plus cin, i.e. op1 + ~op2 + 1
    assign adder_op2 = inv ? ~op2 : op2;
    assign sum = op1 + adder_op2 + {31'b0, cin};

    // ====================
    // Comparator

    // Kept off the adder so branches do not wait on the carry chain
    assign cmp_eq = (op1 == op2);

    always_comb begin
        if (uns) begin
            cmp_lt = (op1 < op2);
        end else begin
            cmp_lt = ($signed(op1) < $signed(op2));
        end
    end

    assign cmp_raw = eq ? cmp_eq : cmp_lt;

    // Inverted form gives bne and bge/bgeu
    assign cmp = cmp_raw ^ inv;

    // ====================
    // Address adder

    assign addr_raw = op3 + op4;

    // jalr clears the LSB of the target
    always_comb begin
        addr = addr_raw;
        if (align) begin
            addr[0] = 1'b0;
        end
    end

endmodule

/* alu/kronos_alu_logic.sv */
// ====================
// Logic half of the ALU: bitwise operations and one 32-bit barrel shifter.
// Left shifts reuse the right shifter through bit reversal.
// ====================

`timescale 1ns/1ps

module kronos_alu_logic
    import kronos_types::*;
(
    input  word_t    op1,
    input  word_t    op2,
    input  logic     rev,
    input  logic     uns,
    input  alu_sel_t sel,
    output word_t    logic_result
);

    logic [4:0] shamt;
    logic       fill;
    word_t      shift_in;
    word_t      shift_stage;
    word_t      shift_result;

    // Mirror a word end to end
    function automatic word_t bit_reverse(input word_t data);
        word_t flipped;
        for (int i = 0; i < 32; i++) begin
            flipped[i] = data[31-i];
        end
        return flipped;
    endfunction

    // ====================
    // Barrel shifter

    assign shamt = op2[4:0];

    // Sign fill only for sra, zeros for srl and sll
    assign fill = ~rev & ~uns & op1[31];

    assign shift_in = rev ? bit_reverse(op1) : op1;

    // Five stages of 1, 2, 4, 8 and 16 bit positions
    always_comb begin
        shift_stage = shift_in;
        for (int i = 0; i < 5; i++) begin
            if (shamt[i]) begin
                shift_stage = (shift_stage >> (1 << i))
                            | ({32{fill}} << (32 - (1 << i)));
            end
        end
    end

    // Undo the reversal for a left shift
    assign shift_result = rev ? bit_reverse(shift_stage) : shift_stage;

    // ====================
    // Bitwise operations and output mux

    always_comb begin
        case (sel)
            ALU_AND: begin
                logic_result = op1 & op2;
            end
            ALU_OR: begin
                logic_result = op1 | op2;
            end
            ALU_XOR: begin
                logic_result = op1 ^ op2;
            end
            default: begin
                // ALU_SHIFT, other codes are not taken from here
                logic_result = shift_result;
            end
        endcase
    end

endmodule

/* alu/kronos_alu.sv */
// ====================
// RV32I ALU, arithmetic and logic parts side by side with a result select.
// Combinational, used by the execute stage.
// ====================

`timescale 1ns/1ps

module kronos_alu
    import kronos_types::*;
(
    input  word_t    op1,
    input  word_t    op2,
    input  word_t    op3,
    input  word_t    op4,
    input  logic     cin,
    input  logic     rev,
    input  logic     uns,
    input  logic     eq,
    input  logic     inv,
    input  logic     align,
    input  alu_sel_t sel,
    output word_t    result1,
    output word_t    result2
);

    word_t sum;
    logic  cmp;
    word_t addr;
    word_t logic_result;

    kronos_alu_arith arith0 (
        .op1   (op1),
        .op2   (op2),
        .op3   (op3),
        .op4   (op4),
        .cin   (cin),
        .inv   (inv),
        .uns   (uns),
        .eq    (eq),
        .align (align),
        .sum   (sum),
        .cmp   (cmp),
        .addr  (addr)
    );

    kronos_alu_logic logic0 (
        .op1          (op1),
        .op2          (op2),
        .rev          (rev),
        .uns          (uns),
        .sel          (sel),
        .logic_result (logic_result)
    );

    // ====================
    // Result select

    always_comb begin
        case (sel)
            ALU_ADD:  result1 = sum;
            ALU_COMP: result1 = {31'b0, cmp};
            ALU_AND, ALU_OR, ALU_XOR, ALU_SHIFT: result1 = logic_result;
            default:  result1 = sum;
        endcase
    end

    // Branch/jump target or load/store address
    assign result2 = addr;

    // Decoder must only ever hand over a defined select code
    always_comb begin
        assert ($isunknown(sel) || sel inside {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR,
                                               ALU_SHIFT, ALU_COMP})
            else $error("ALU select code %0d is not defined", sel);
    end

endmodule

/* rtl/kronos_ex.sv */
// ====================
// Execute pipestage: ALU plus one output register with valid/ready and flush.
// Forwards the writeback controls alongside the results.
// ====================

`timescale 1ns/1ps

module kronos_ex
    import kronos_types::*;
(
    input  logic       clk,
    input  logic       rstz,
    input  logic       flush,
    // Decoded instruction
    input  word_t      op1,
    input  word_t      op2,
    input  word_t      op3,
    input  word_t      op4,
    input  logic       cin,
    input  logic       rev,
    input  logic       uns,
    input  logic       eq,
    input  logic       inv,
    input  logic       align,
    input  alu_sel_t   sel,
    input  reg_addr_t  rd,
    input  logic       rd_write,
    input  logic       branch,
    input  logic       branch_cond,
    input  logic       ld,
    input  logic       st,
    input  data_size_t data_size,
    input  logic       data_uns,
    input  logic       is_illegal,
    input  logic       is_ecall,
    input  logic       pipe_in_vld,
    output logic       pipe_in_rdy,
    // Execute results toward writeback
    output word_t      result1,
    output word_t      result2,
    output reg_addr_t  out_rd,
    output logic       out_rd_write,
    output logic       out_branch,
    output logic       out_branch_cond,
    output logic       out_ld,
    output logic       out_st,
    output data_size_t out_data_size,
    output logic       out_data_uns,
    output logic       out_is_illegal,
    output logic       out_is_ecall,
    output logic       pipe_out_vld,
    input  logic       pipe_out_rdy
);

    word_t alu_result1;
    word_t alu_result2;
    logic  accept;

    kronos_alu alu0 (
        .op1     (op1),
        .op2     (op2),
        .op3     (op3),
        .op4     (op4),
        .cin     (cin),
        .rev     (rev),
        .uns     (uns),
        .eq      (eq),
        .inv     (inv),
        .align   (align),
        .sel     (sel),
        .result1 (alu_result1),
        .result2 (alu_result2)
    );

    // Register is free, or its item leaves this cycle
    assign pipe_in_rdy = ~pipe_out_vld | pipe_out_rdy;
    assign accept = pipe_in_vld & pipe_in_rdy;

    // ====================
    // Output register

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pipe_out_vld <= 1'b0;
        end else if (flush) begin
            pipe_out_vld <= 1'b0;
        end else if (accept) begin
            pipe_out_vld <= 1'b1;
        end else if (pipe_out_rdy) begin
            pipe_out_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !flush) begin
            result1         <= alu_result1;
            result2         <= alu_result2;
            out_rd          <= rd;
            out_rd_write    <= rd_write;
            out_branch      <= branch;
            out_branch_cond <= branch_cond;
            out_ld          <= ld;
            out_st          <= st;
            out_data_size   <= data_size;
            out_data_uns    <= data_uns;
            out_is_illegal  <= is_illegal;
            out_is_ecall    <= is_ecall;
        end
    end

    // ====================
    // Assertions

    // Held item stays put until writeback takes it
    a_stall_stable: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld && !pipe_out_rdy && !flush |=> pipe_out_vld
            && $stable({result1, result2, out_rd, out_rd_write, out_branch,
                        out_branch_cond, out_ld, out_st, out_data_size,
                        out_data_uns, out_is_illegal, out_is_ecall}))
        else $error("EX output changed while stalled");

    a_flush_clears: assert property (@(posedge clk) disable iff (!rstz)
        flush |=> !pipe_out_vld)
        else $error("EX output still valid after flush");

    // Empty stage must never stall decode
    a_empty_ready: assert property (@(posedge clk) disable iff (!rstz)
        !pipe_out_vld && pipe_in_vld && !flush |=> pipe_out_vld)
        else $error("EX did not take an offered item while empty");

endmodule

/* rtl/kronos_ex_top.sv */
// ====================
// Execute subsystem top level, connects the stage to the outside.
// ====================

`timescale 1ns/1ps

module kronos_ex_top
    import kronos_types::*;
(
    input  logic       clk,
    input  logic       rstz,
    input  logic       flush,
    input  word_t      op1,
    input  word_t      op2,
    input  word_t      op3,
    input  word_t      op4,
    input  logic       cin,
    input  logic       rev,
    input  logic       uns,
    input  logic       eq,
    input  logic       inv,
    input  logic       align,
    input  alu_sel_t   sel,
    input  reg_addr_t  rd,
    input  logic       rd_write,
    input  logic       branch,
    input  logic       branch_cond,
    input  logic       ld,
    input  logic       st,
    input  data_size_t data_size,
    input  logic       data_uns,
    input  logic       is_illegal,
    input  logic       is_ecall,
    input  logic       pipe_in_vld,
    output logic       pipe_in_rdy,
    output word_t      result1,
    output word_t      result2,
    output reg_addr_t  out_rd,
    output logic       out_rd_write,
    output logic       out_branch,
    output logic       out_branch_cond,
    output logic       out_ld,
    output logic       out_st,
    output data_size_t out_data_size,
    output logic       out_data_uns,
    output logic       out_is_illegal,
    output logic       out_is_ecall,
    output logic       pipe_out_vld,
    input  logic       pipe_out_rdy
);

    // Port names match one to one
    kronos_ex ex0 (
        .*
    );

endmodule

/* tb/tb_kronos_ex.sv */
// ====================
// Testbench for the execute subsystem. Random legal instructions, a model queue
// and concurrent assertions that check every output transfer.
// ====================

`timescale 1ns/1ps

module tb_kronos_ex;
    import kronos_types::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_XFERS    = 2000;
    // Average cycles per transfer with random stalls and flushes
    localparam int STALL_FACTOR = 3;
    localparam int TIMEOUT_NS   =
        (RESET_CYCLES + NUM_XFERS * STALL_FACTOR) * CLK_PERIOD * 3 / 2;

    typedef struct packed {
        word_t      r1;
        word_t      r2;
        reg_addr_t  rd;
        logic       rd_write;
        logic       branch;
        logic       branch_cond;
        logic       ld;
        logic       st;
        data_size_t data_size;
        logic       data_uns;
        logic       is_illegal;
        logic       is_ecall;
    } exp_t;

    logic       clk;
    logic       rstz;
    logic       flush;
    word_t      op1, op2, op3, op4;
    logic       cin, rev, uns, eq, inv, align;
    alu_sel_t   sel;
    reg_addr_t  rd;
    logic       rd_write, branch, branch_cond, ld, st;
    data_size_t data_size;
    logic       data_uns, is_illegal, is_ecall;
    logic       pipe_in_vld;
    logic       pipe_in_rdy;
    word_t      result1, result2;
    reg_addr_t  out_rd;
    logic       out_rd_write, out_branch, out_branch_cond, out_ld, out_st;
    data_size_t out_data_size;
    logic       out_data_uns, out_is_illegal, out_is_ecall;
    logic       pipe_out_vld;
    logic       pipe_out_rdy;

    integer seed;
    int     xfer_count;
    exp_t   exp_q[$];
    exp_t   head;
    logic   head_vld;
    exp_t   next_exp;
    exp_t   actual;

    kronos_ex_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign actual = {result1, result2, out_rd, out_rd_write, out_branch, out_branch_cond,
                     out_ld, out_st, out_data_size, out_data_uns, out_is_illegal,
                     out_is_ecall};

    // ====================
    // Failure reporting

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        abort_run();
    endtask

    // ====================
    // Random helpers

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic logic rand_bit();
        word_t w;
        w = rand_word();
        return w[0];
    endfunction

    function automatic int rand_below(input int n);
        word_t w;
        w = rand_word();
        return int'(w % word_t'(n));
    endfunction

    // ====================
    // Reference model from the ALU rules

    function automatic word_t expect_result1(input word_t a, input word_t b, input logic c_in,
                                             input logic rv, input logic un, input logic eqs,
                                             input logic iv, input alu_sel_t s);
        word_t b_eff;
        word_t r;
        logic  c;
        b_eff = iv ? ~b : b;
        if (eqs) begin
            c = (a == b);
        end else if (un) begin
            c = (a < b);
        end else begin
            c = ($signed(a) < $signed(b));
        end
        c = c ^ iv;
        case (s)
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_COMP: r = {31'b0, c};
            ALU_SHIFT: begin
                if (rv) begin
                    r = a << b[4:0];
                end else if (un) begin
                    r = a >> b[4:0];
                end else begin
                    r = word_t'($signed(a) >>> b[4:0]);
                end
            end
            default:  r = a + b_eff + {31'b0, c_in};
        endcase
        return r;
    endfunction

    function automatic word_t expect_result2(input word_t a, input word_t b, input logic al);
        word_t r;
        r = a + b;
        if (al) begin
            r[0] = 1'b0;
        end
        return r;
    endfunction

    // Queue follows the output register, one entry per held item
    always @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            exp_q.delete();
            head_vld = 1'b0;
            head = '0;
        end else begin
            if (pipe_out_vld && pipe_out_rdy) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                xfer_count++;
            end
            if (flush) begin
                exp_q.delete();
            end else if (pipe_in_vld && pipe_in_rdy) begin
                next_exp = {expect_result1(op1, op2, cin, rev, uns, eq, inv, sel),
                            expect_result2(op3, op4, align), rd, rd_write, branch,
                            branch_cond, ld, st, data_size, data_uns, is_illegal,
                            is_ecall};
                exp_q.push_back(next_exp);
            end
            head_vld = (exp_q.size() != 0);
            if (head_vld) begin
                head = exp_q[0];
            end
        end
    end

    // ====================
    // Checks

    a_reset_vld: assert property (@(posedge clk) !rstz |-> !pipe_out_vld)
        else report_mismatch("pipe_out_vld high during reset");

    // Catches lost, duplicated, late and unflushed items
    a_vld_tracks: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld == head_vld)
        else report_mismatch($sformatf("pipe_out_vld %0b, model expects %0b",
                                       $sampled(pipe_out_vld), $sampled(head_vld)));

    a_result: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld && pipe_out_rdy |-> actual == head)
        else report_mismatch($sformatf("output %h, expected %h",
                                       $sampled(actual), $sampled(head)));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld && !pipe_out_rdy && !flush |=> pipe_out_vld && $stable(actual))
        else report_mismatch("outputs changed while stalled");

    a_stall_rdy: assert property (@(posedge clk) disable iff (!rstz)
        pipe_out_vld && !pipe_out_rdy |-> !pipe_in_rdy)
        else report_mismatch("pipe_in_rdy high while output stalled");

    // ====================
    // Stimulus

    // Legal instruction forms only
    task automatic drive_instruction();
        alu_sel_t s;
        word_t    a;
        logic     b0;
        s = alu_sel_t'(rand_below(6));
        a = rand_word();
        b0 = rand_bit();
        op1 <= a;
        op2 <= (s == ALU_COMP && rand_below(4) == 0) ? a : rand_word();
        op3 <= rand_word();
        op4 <= rand_word();
        align <= rand_bit();
        sel <= s;
        cin <= 1'b0;
        rev <= 1'b0;
        uns <= 1'b0;
        eq <= 1'b0;
        inv <= 1'b0;
        if (s == ALU_ADD) begin
            // sub when set
            inv <= b0;
            cin <= b0;
        end else if (s == ALU_SHIFT) begin
            rev <= b0;
            uns <= b0 | rand_bit();
        end else if (s == ALU_COMP) begin
            eq <= b0;
            uns <= rand_bit();
            inv <= rand_bit();
        end
        rd <= reg_addr_t'(rand_word());
        rd_write <= rand_bit();
        branch <= rand_bit();
        branch_cond <= rand_bit();
        ld <= rand_bit();
        st <= rand_bit();
        data_size <= data_size_t'(rand_word());
        data_uns <= rand_bit();
        is_illegal <= rand_bit();
        is_ecall <= rand_bit();
    endtask

    always @(posedge clk) begin
        if (!rstz) begin
            pipe_in_vld <= 1'b0;
            pipe_out_rdy <= 1'b0;
            flush <= 1'b0;
        end else begin
            pipe_out_rdy <= (rand_below(3) != 0);
            flush <= (rand_below(16) == 0);
            // Hold an offered instruction until it is taken
            if (!pipe_in_vld || pipe_in_rdy) begin
                pipe_in_vld <= (rand_below(4) != 0);
                drive_instruction();
            end
        end
    end

    initial begin
        seed = 32'h83c7b2e6;
        xfer_count = 0;
        clk = 1'b0;
        rstz = 1'b0;
        flush = 1'b0;
        {op1, op2, op3, op4} = '0;
        {cin, rev, uns, eq, inv, align} = '0;
        sel = ALU_ADD;
        {rd, rd_write, branch, branch_cond, ld, st} = '0;
        {data_size, data_uns, is_illegal, is_ecall} = '0;
        pipe_in_vld = 1'b0;
        pipe_out_rdy = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstz <= 1'b1;
        wait (xfer_count >= NUM_XFERS);
        // One more edge so the last transfer is checked
        @(posedge clk);
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: only %0d of %0d transfers done", xfer_count, NUM_XFERS);
        abort_run();
    end

endmodule

/* project.f */
common/kronos_types.sv
alu/kronos_alu_arith.sv
alu/kronos_alu_logic.sv
alu/kronos_alu.sv
rtl/kronos_ex.sv
rtl/kronos_ex_top.sv
tb/tb_kronos_ex.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_kronos_ex \
    --Mdir obj_dir -o sim_tb \
    -f project.f

# Pass only when the testbench printed its pass line
if ./obj_dir/sim_tb | tee /dev/stderr | grep -x "sim passed" > /dev/null; then
    exit 0
else
    exit 1
fi
